/* logic/tetris_pkg.sv */
package tetris_pkg;

	////////////////////////////////////////////////////////////
	// Board geometry

	localparam int WELL_COLS = 10;	// Well width in cells
	localparam int WELL_ROWS = 20;	// Well depth in cells
	localparam int WELL_X0 = 10;	// Board column of the left wall
	localparam int WELL_Y0 = 5;	// Board row of the top edge

	typedef logic [5:0] col_t;	// Board column
	typedef logic [4:0] row_t;	// Board row
	typedef logic [10:0] addr_t;	// Row in the upper bits, column below
	typedef logic [2:0] color_t;	// Zero is an empty cell

	////////////////////////////////////////////////////////////
	// Pieces

	typedef logic [1:0] off_t;	// Offset inside the 4x4 shape box
	typedef logic [2:0] kind_t;	// I O J L S Z T as 1 to 7
	typedef logic [1:0] rot_t;

	// Spawn corner of the shape box, relative to the well
	localparam int SPAWN_X = 3;
	localparam int SPAWN_Y = 0;

	////////////////////////////////////////////////////////////
	// Frame schedule

	typedef logic [5:0] step_t;	// Zero while idle

	// Each check spans six steps from its base
	localparam step_t STEP_CHK_DOWN = 6'd1;
	localparam step_t STEP_CHK_LEFT = 6'd7;
	localparam step_t STEP_CHK_RIGHT = 6'd13;
	localparam step_t STEP_CHK_ROT = 6'd19;
	localparam step_t STEP_ERASE = 6'd25;	// Four erase writes
	localparam step_t STEP_UPDATE = 6'd29;	// Move, rotate or spawn
	localparam step_t STEP_DRAW = 6'd30;	// Four draw writes
	localparam step_t STEP_LAST = 6'd34;

endpackage

/* logic/shape_rom.sv */
`timescale 1ns/1ps

module shape_rom (
	input  tetris_pkg::kind_t      kind,
	input  tetris_pkg::rot_t       rot,
	output tetris_pkg::off_t [3:0] dx,
	output tetris_pkg::off_t [3:0] dy
);

	logic [15:0] cells;	// Four (x, y) pairs, cell 0 in the top bits

	always_comb
	begin
		case ({kind, rot})
			// I
			{3'd1, 2'd0}: cells = {2'd0, 2'd1, 2'd1, 2'd1, 2'd2, 2'd1, 2'd3, 2'd1};
			{3'd1, 2'd1}: cells = {2'd2, 2'd0, 2'd2, 2'd1, 2'd2, 2'd2, 2'd2, 2'd3};
			{3'd1, 2'd2}: cells = {2'd0, 2'd2, 2'd1, 2'd2, 2'd2, 2'd2, 2'd3, 2'd2};
			{3'd1, 2'd3}: cells = {2'd1, 2'd0, 2'd1, 2'd1, 2'd1, 2'd2, 2'd1, 2'd3};
			// O, same in every rotation
			{3'd2, 2'd0}, {3'd2, 2'd1}, {3'd2, 2'd2}, {3'd2, 2'd3}:
				cells = {2'd1, 2'd0, 2'd2, 2'd0, 2'd1, 2'd1, 2'd2, 2'd1};
			// J
			{3'd3, 2'd0}: cells = {2'd0, 2'd0, 2'd0, 2'd1, 2'd1, 2'd1, 2'd2, 2'd1};
			{3'd3, 2'd1}: cells = {2'd1, 2'd0, 2'd2, 2'd0, 2'd1, 2'd1, 2'd1, 2'd2};
			{3'd3, 2'd2}: cells = {2'd0, 2'd1, 2'd1, 2'd1, 2'd2, 2'd1, 2'd2, 2'd2};
			{3'd3, 2'd3}: cells = {2'd1, 2'd0, 2'd1, 2'd1, 2'd0, 2'd2, 2'd1, 2'd2};
			// L
			{3'd4, 2'd0}: cells = {2'd2, 2'd0, 2'd0, 2'd1, 2'd1, 2'd1, 2'd2, 2'd1};
			{3'd4, 2'd1}: cells = {2'd1, 2'd0, 2'd1, 2'd1, 2'd1, 2'd2, 2'd2, 2'd2};
			{3'd4, 2'd2}: cells = {2'd0, 2'd1, 2'd1, 2'd1, 2'd2, 2'd1, 2'd0, 2'd2};
			{3'd4, 2'd3}: cells = {2'd0, 2'd0, 2'd1, 2'd0, 2'd1, 2'd1, 2'd1, 2'd2};
			// S
			{3'd5, 2'd0}: cells = {2'd1, 2'd0, 2'd2, 2'd0, 2'd0, 2'd1, 2'd1, 2'd1};
			{3'd5, 2'd1}: cells = {2'd1, 2'd0, 2'd1, 2'd1, 2'd2, 2'd1, 2'd2, 2'd2};
			{3'd5, 2'd2}: cells = {2'd1, 2'd1, 2'd2, 2'd1, 2'd0, 2'd2, 2'd1, 2'd2};
			{3'd5, 2'd3}: cells = {2'd0, 2'd0, 2'd0, 2'd1, 2'd1, 2'd1, 2'd1, 2'd2};
			// Z
			{3'd6, 2'd0}: cells = {2'd0, 2'd0, 2'd1, 2'd0, 2'd1, 2'd1, 2'd2, 2'd1};
			{3'd6, 2'd1}: cells = {2'd2, 2'd0, 2'd1, 2'd1, 2'd2, 2'd1, 2'd1, 2'd2};
			{3'd6, 2'd2}: cells = {2'd0, 2'd1, 2'd1, 2'd1, 2'd1, 2'd2, 2'd2, 2'd2};
			{3'd6, 2'd3}: cells = {2'd1, 2'd0, 2'd0, 2'd1, 2'd1, 2'd1, 2'd0, 2'd2};
			// T
			{3'd7, 2'd0}: cells = {2'd1, 2'd0, 2'd0, 2'd1, 2'd1, 2'd1, 2'd2, 2'd1};
			{3'd7, 2'd1}: cells = {2'd1, 2'd0, 2'd1, 2'd1, 2'd2, 2'd1, 2'd1, 2'd2};
			{3'd7, 2'd2}: cells = {2'd0, 2'd1, 2'd1, 2'd1, 2'd2, 2'd1, 2'd1, 2'd2};
			{3'd7, 2'd3}: cells = {2'd1, 2'd0, 2'd0, 2'd1, 2'd1, 2'd1, 2'd1, 2'd2};
			default: cells = '0;	// Kind 0 never reaches here
		endcase

		// Split the pairs into the two offset vectors
		for (int i = 0; i < 4; i++)
		begin
			dx[i] = cells[15 - 4 * i -: 2];
			dy[i] = cells[13 - 4 * i -: 2];
		end
	end

endmodule

/* logic/frame_sequencer.sv */
`timescale 1ns/1ps

module frame_sequencer #(
	parameter int GRAVITY_FRAMES = 4
) (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              frame,
	input  logic              btn_left,
	input  logic              btn_right,
	input  logic              btn_rot,
	output logic              busy,
	output tetris_pkg::step_t step,
	output logic              gravity_due,
	output logic              req_left,
	output logic              req_right,
	output logic              req_rot
);
	import tetris_pkg::*;

	localparam int GRAV_W = $clog2(GRAVITY_FRAMES + 1);

	logic [GRAV_W-1:0] grav_cnt;	// Accepted frames since the last fall try
	logic              frame_start;

	assign busy = (step != '0);
	assign frame_start = frame && !busy;	// Pulses inside a frame are dropped

	// Step counter, 1 to STEP_LAST then idle
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			step <= '0;
		else if (frame_start)
			step <= STEP_CHK_DOWN;
		else if (step == STEP_LAST)
			step <= '0;
		else if (busy)
			step <= step + 6'd1;
	end

	////////////////////////////////////////////////////////////
	// Per frame state, captured once at frame start

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			grav_cnt <= '0;
			gravity_due <= 1'b0;
			req_left <= 1'b0;
			req_right <= 1'b0;
			req_rot <= 1'b0;
		end
		else if (frame_start)
		begin
			req_left <= btn_left;	// Button levels sampled here only
			req_right <= btn_right;
			req_rot <= btn_rot;
			// Wrap of the divider marks a gravity frame
			if (grav_cnt == GRAV_W'(GRAVITY_FRAMES - 1))
			begin
				grav_cnt <= '0;
				gravity_due <= 1'b1;
			end
			else
			begin
				grav_cnt <= grav_cnt + 1'b1;
				gravity_due <= 1'b0;
			end
		end
	end

endmodule

/* logic/collision_checker.sv */
`timescale 1ns/1ps

module collision_checker (
	input  logic                   clk,
	input  logic                   arst_n,
	input  tetris_pkg::step_t      step,
	input  tetris_pkg::col_t       pos_x,
	input  tetris_pkg::row_t       pos_y,
	input  tetris_pkg::kind_t      kind,
	input  tetris_pkg::rot_t       rot,
	input  tetris_pkg::col_t [3:0] cur_x,
	input  tetris_pkg::row_t [3:0] cur_y,
	input  tetris_pkg::color_t     rd_data,
	output tetris_pkg::addr_t      rd_addr,
	output logic                   can_down,
	output logic                   can_left,
	output logic                   can_right,
	output logic                   can_rot
);
	import tetris_pkg::*;

	localparam logic [1:0] CHK_DOWN = 2'd0;
	localparam logic [1:0] CHK_LEFT = 2'd1;
	localparam logic [1:0] CHK_RIGHT = 2'd2;
	localparam logic [1:0] CHK_ROT = 2'd3;

	rot_t             next_rot;
	off_t [3:0]       rot_dx;
	off_t [3:0]       rot_dy;
	logic [1:0]       sel;	// Active check
	step_t            base;
	step_t            rel;
	logic [1:0]       idx;	// Candidate cell being addressed
	logic             issue;
	col_t             cand_x;
	row_t             cand_y;
	logic             oob;
	logic             own;
	logic [3:0]       can_flags;
	logic             pend_valid;	// A read is coming back this cycle
	logic [1:0]       pend_sel;
	logic             pend_oob;
	logic             pend_own;

	assign next_rot = rot + 2'd1;

	// Shape of the rotation candidate
	shape_rom shape_rom_inst (
		.kind(kind),
		.rot (next_rot),
		.dx  (rot_dx),
		.dy  (rot_dy)
	);

	////////////////////////////////////////////////////////////
	// Which check owns this step

	always_comb
	begin
		if (step >= STEP_CHK_ROT)
		begin
			sel = CHK_ROT;
			base = STEP_CHK_ROT;
		end
		else if (step >= STEP_CHK_RIGHT)
		begin
			sel = CHK_RIGHT;
			base = STEP_CHK_RIGHT;
		end
		else if (step >= STEP_CHK_LEFT)
		begin
			sel = CHK_LEFT;
			base = STEP_CHK_LEFT;
		end
		else
		begin
			sel = CHK_DOWN;
			base = STEP_CHK_DOWN;
		end
		rel = step - base;
		issue = (step >= STEP_CHK_DOWN) && (rel < 6'd4);	// Base plus 0 to 3
		idx = rel[1:0];
	end

	// Candidate cell, bounds and own-cell test
	always_comb
	begin
		cand_x = cur_x[idx];
		cand_y = cur_y[idx];
		case (sel)
			CHK_DOWN:  cand_y = cur_y[idx] + 5'd1;
			CHK_LEFT:  cand_x = cur_x[idx] - 6'd1;
			CHK_RIGHT: cand_x = cur_x[idx] + 6'd1;
			default:
			begin
				cand_x = pos_x + col_t'(rot_dx[idx]);	// Same corner, next shape
				cand_y = pos_y + row_t'(rot_dy[idx]);
			end
		endcase
		oob = (cand_x < col_t'(WELL_X0)) || (cand_x >= col_t'(WELL_X0 + WELL_COLS))
			|| (cand_y >= row_t'(WELL_Y0 + WELL_ROWS));
		own = 1'b0;
		// Cells of the piece itself never block
		for (int i = 0; i < 4; i++)
			if ((cur_x[i] == cand_x) && (cur_y[i] == cand_y))
				own = 1'b1;
	end

	assign rd_addr = {cand_y, cand_x};

	////////////////////////////////////////////////////////////
	// Flags, set at the base step and cleared by a blocking cell

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			can_flags <= '0;
			pend_valid <= 1'b0;
			pend_sel <= CHK_DOWN;
			pend_oob <= 1'b0;
			pend_own <= 1'b0;
		end
		else
		begin
			pend_valid <= issue;	// Board answers one clock later
			pend_sel <= sel;
			pend_oob <= oob;
			pend_own <= own;
			if (issue && (idx == 2'd0))
				can_flags[sel] <= 1'b1;
			if (pend_valid && (pend_oob || ((rd_data != '0) && !pend_own)))
				can_flags[pend_sel] <= 1'b0;
		end
	end

	assign can_down = can_flags[CHK_DOWN];
	assign can_left = can_flags[CHK_LEFT];
	assign can_right = can_flags[CHK_RIGHT];
	assign can_rot = can_flags[CHK_ROT];

endmodule

/* logic/piece_state.sv */
`timescale 1ns/1ps

module piece_state (
	input  logic                   clk,
	input  logic                   arst_n,
	input  tetris_pkg::step_t      step,
	input  logic                   gravity_due,
	input  logic                   req_left,
	input  logic                   req_right,
	input  logic                   req_rot,
	input  logic                   can_down,
	input  logic                   can_left,
	input  logic                   can_right,
	input  logic                   can_rot,
	output tetris_pkg::col_t       pos_x,
	output tetris_pkg::row_t       pos_y,
	output tetris_pkg::rot_t       rot,
	output tetris_pkg::kind_t      kind,
	output tetris_pkg::col_t [3:0] cur_x,
	output tetris_pkg::row_t [3:0] cur_y,
	output logic                   lock
);
	import tetris_pkg::*;

	// Box corner in board coordinates, so a left shift never goes negative
	localparam col_t SPAWN_COL = col_t'(WELL_X0 + SPAWN_X);
	localparam row_t SPAWN_ROW = row_t'(WELL_Y0 + SPAWN_Y);

	off_t [3:0] dx;
	off_t [3:0] dy;
	kind_t      next_kind;	// Free running 1 to 7

	shape_rom shape_rom_inst (
		.kind(kind),
		.rot (rot),
		.dx  (dx),
		.dy  (dy)
	);

	// Absolute board cells of the piece
	always_comb
	begin
		for (int i = 0; i < 4; i++)
		begin
			cur_x[i] = pos_x + col_t'(dx[i]);
			cur_y[i] = pos_y + row_t'(dy[i]);
		end
	end

	// Flags are stable from the erase step to the end of the frame
	assign lock = gravity_due && !can_down && (step >= STEP_ERASE);

	////////////////////////////////////////////////////////////
	// Piece registers

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			pos_x <= SPAWN_COL;
			pos_y <= SPAWN_ROW;
			rot <= '0;
			kind <= 3'd1;
			next_kind <= 3'd1;
		end
		else
		begin
			if (step == STEP_CHK_DOWN)	// Once per accepted frame
				next_kind <= (next_kind == 3'd7) ? 3'd1 : next_kind + 3'd1;
			if (step == STEP_UPDATE)
			begin
				// One action per frame, gravity first
				if (gravity_due && can_down)
					pos_y <= pos_y + 5'd1;
				else if (lock)
				begin
					kind <= next_kind;	// Old cells stay on the board
					rot <= '0;
					pos_x <= SPAWN_COL;
					pos_y <= SPAWN_ROW;
				end
				else if (req_rot && can_rot)
					rot <= rot + 2'd1;
				else if (req_left && can_left)
					pos_x <= pos_x - 6'd1;
				else if (req_right && can_right)
					pos_x <= pos_x + 6'd1;
			end
		end
	end

endmodule

/* logic/board_writer.sv */
`timescale 1ns/1ps

module board_writer (
	input  logic                   clk,
	input  logic                   arst_n,
	input  tetris_pkg::step_t      step,
	input  logic                   lock,
	input  tetris_pkg::col_t [3:0] cur_x,
	input  tetris_pkg::row_t [3:0] cur_y,
	input  tetris_pkg::kind_t      kind,
	output tetris_pkg::addr_t      wr_addr,
	output tetris_pkg::color_t     wr_data,
	output logic                   wr_en
);
	import tetris_pkg::*;

	logic       erase;
	logic       draw;
	step_t      rel;
	logic [1:0] idx;	// Cell written next

	always_comb
	begin
		erase = (step >= STEP_ERASE) && (step < STEP_UPDATE) && !lock;	// Locked cells stay
		draw = (step >= STEP_DRAW) && (step < STEP_LAST);
		rel = erase ? (step - STEP_ERASE) : (step - STEP_DRAW);
		idx = rel[1:0];
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			wr_en <= 1'b0;
		else
			wr_en <= erase || draw;	// Write lands one step later
	end

	// Draw sees the piece after the update step
	always_ff @(posedge clk)
	begin
		wr_addr <= {cur_y[idx], cur_x[idx]};
		wr_data <= draw ? color_t'(kind) : '0;	// Kind is the colour
	end

endmodule

/* logic/tetris_game.sv */
`timescale 1ns/1ps

module tetris_game #(
	parameter int GRAVITY_FRAMES = 4	// Frames per fall try
) (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               frame,
	input  logic               btn_left,
	input  logic               btn_right,
	input  logic               btn_rot,
	input  tetris_pkg::color_t rd_data,
	output logic               busy,
	output tetris_pkg::addr_t  rd_addr,
	output tetris_pkg::addr_t  wr_addr,
	output tetris_pkg::color_t wr_data,
	output logic               wr_en
);
	import tetris_pkg::*;

	step_t      step;
	logic       gravity_due;
	logic       req_left;	// Buttons held for the frame
	logic       req_right;
	logic       req_rot;
	col_t       pos_x;
	row_t       pos_y;
	rot_t       rot;
	kind_t      kind;
	col_t [3:0] cur_x;	// Current cells on the board
	row_t [3:0] cur_y;
	logic       lock;
	logic       can_down;
	logic       can_left;
	logic       can_right;
	logic       can_rot;

	////////////////////////////////////////////////////////////
	// Schedule and gravity

	frame_sequencer #(
		.GRAVITY_FRAMES(GRAVITY_FRAMES)
	) frame_sequencer_inst (
		.clk        (clk),
		.arst_n     (arst_n),
		.frame      (frame),
		.btn_left   (btn_left),
		.btn_right  (btn_right),
		.btn_rot    (btn_rot),
		.busy       (busy),
		.step       (step),
		.gravity_due(gravity_due),
		.req_left   (req_left),
		.req_right  (req_right),
		.req_rot    (req_rot)
	);

	////////////////////////////////////////////////////////////
	// Board reads, piece, board writes

	collision_checker collision_checker_inst (
		.clk      (clk),
		.arst_n   (arst_n),
		.step     (step),
		.pos_x    (pos_x),
		.pos_y    (pos_y),
		.kind     (kind),
		.rot      (rot),
		.cur_x    (cur_x),
		.cur_y    (cur_y),
		.rd_data  (rd_data),
		.rd_addr  (rd_addr),
		.can_down (can_down),
		.can_left (can_left),
		.can_right(can_right),
		.can_rot  (can_rot)
	);

	piece_state piece_state_inst (
		.clk        (clk),
		.arst_n     (arst_n),
		.step       (step),
		.gravity_due(gravity_due),
		.req_left   (req_left),
		.req_right  (req_right),
		.req_rot    (req_rot),
		.can_down   (can_down),
		.can_left   (can_left),
		.can_right  (can_right),
		.can_rot    (can_rot),
		.pos_x      (pos_x),
		.pos_y      (pos_y),
		.rot        (rot),
		.kind       (kind),
		.cur_x      (cur_x),
		.cur_y      (cur_y),
		.lock       (lock)
	);

	board_writer board_writer_inst (
		.clk    (clk),
		.arst_n (arst_n),
		.step   (step),
		.lock   (lock),
		.cur_x  (cur_x),
		.cur_y  (cur_y),
		.kind   (kind),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.wr_en  (wr_en)
	);

endmodule

/* testbench/tetris_game_chk.sv */
`timescale 1ns/1ps

module tetris_game_chk (
	input logic              clk,
	input logic              arst_n,
	input logic              busy,
	input logic              wr_en,
	input tetris_pkg::addr_t wr_addr
);
	import tetris_pkg::*;

	col_t wr_col;
	row_t wr_row;

	assign wr_col = wr_addr[5:0];	// Column in the low bits
	assign wr_row = wr_addr[10:6];

	////////////////////////////////////////////////////////////
	// Port rules

	wr_in_frame: assert property (@(posedge clk) disable iff (!arst_n) wr_en |-> busy)
		else $error("board write outside a frame");

	// Idle through reset and on the first edge after it
	reset_idle: assert property (@(posedge clk)
		(!arst_n || $rose(arst_n)) |-> (!busy && !wr_en))
		else $error("busy or wr_en set around reset");

	wr_in_well: assert property (@(posedge clk) disable iff (!arst_n)
		wr_en |-> (wr_col >= col_t'(WELL_X0)) && (wr_col < col_t'(WELL_X0 + WELL_COLS))
			&& (wr_row >= row_t'(WELL_Y0)) && (wr_row < row_t'(WELL_Y0 + WELL_ROWS)))
		else $error("board write outside the well at %h", wr_addr);

endmodule

bind tetris_game tetris_game_chk tetris_game_chk_inst (
	.clk    (clk),
	.arst_n (arst_n),
	.busy   (busy),
	.wr_en  (wr_en),
	.wr_addr(wr_addr)
);

/* testbench/tb_tetris_game.sv */
`timescale 1ns/1ps

module tb_tetris_game;
	import tetris_pkg::*;

	localparam int GRAVITY = 3;	// Fall try every third frame
	localparam int NUM_FRAMES = 200;
	localparam int FRAME_GAP = 12;	// Idle cycles, frames start 48 cycles apart
	localparam int TIMEOUT = NUM_FRAMES * 48 + 200;

	logic   clk = 1'b0;
	logic   arst_n = 1'b0;
	logic   frame = 1'b0;
	logic   btn_left = 1'b0;
	logic   btn_right = 1'b0;
	logic   btn_rot = 1'b0;
	color_t rd_data = '0;
	logic   busy;
	addr_t  rd_addr;
	addr_t  wr_addr;
	color_t wr_data;
	logic   wr_en;

	color_t board [0:2047] = '{default: '0};	// Memory the DUT works on
	color_t ref_board [0:2047] = '{default: '0};	// Expected contents

	// Reference piece, box corner in board coordinates
	int m_x = WELL_X0 + SPAWN_X;
	int m_y = WELL_Y0 + SPAWN_Y;
	int m_rot = 0;
	int m_kind = 1;
	int m_next = 1;
	int m_grav = 0;
	int locks = 0;
	int rotations = 0;

	int          cycles = 0;
	int          checks = 0;
	int          errors = 0;
	int          test_errors = 0;
	int          tests_run = 0;
	int          tests_bad = 0;
	logic [31:0] rng = 32'hd109_0f25;

	tetris_game #(
		.GRAVITY_FRAMES(GRAVITY)
	) tetris_game_inst (
		.clk      (clk),
		.arst_n   (arst_n),
		.frame    (frame),
		.btn_left (btn_left),
		.btn_right(btn_right),
		.btn_rot  (btn_rot),
		.rd_data  (rd_data),
		.busy     (busy),
		.rd_addr  (rd_addr),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data),
		.wr_en    (wr_en)
	);

	always #20 clk = ~clk;

	// Board memory, registered read
	always @(posedge clk)
	begin
		rd_data <= board[rd_addr];
		if (wr_en)
			board[wr_addr] <= wr_data;
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT)
		begin
			$display("timeout: run still going after %0d cycles", TIMEOUT);
			$display("tests failed");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	////////////////////////////////////////////////////////////
	// Reference model of the piece

	// One 4x4 bitmap per rotation, bit 4*y+x, rotation 0 in the low word
	function automatic logic [15:0] shape_mask(input int kind, input int rot);
		logic [63:0] rots;
		case (kind)
			1: rots = 64'h2222_0F00_4444_00F0;	// I
			2: rots = 64'h0066_0066_0066_0066;	// O
			3: rots = 64'h0322_0470_0226_0071;	// J
			4: rots = 64'h0223_0170_0622_0074;	// L
			5: rots = 64'h0231_0360_0462_0036;	// S
			6: rots = 64'h0132_0630_0264_0063;	// Z
			7: rots = 64'h0232_0270_0262_0072;	// T
			default: rots = '0;
		endcase
		return rots[16 * (rot % 4) +: 16];
	endfunction

	function automatic bit is_own(input int x, input int y);
		logic [15:0] m;
		m = shape_mask(m_kind, m_rot);
		if (x < m_x || y < m_y || x > m_x + 3 || y > m_y + 3)
			return 1'b0;
		return m[4 * (y - m_y) + (x - m_x)];
	endfunction

	// True when the shape at this corner hits no wall, floor or foreign cell
	function automatic bit fits(input int rot, input int x, input int y);
		logic [15:0] m;
		int          cx;
		int          cy;
		m = shape_mask(m_kind, rot);
		for (int i = 0; i < 16; i++)
		begin
			if (m[i])
			begin
				cx = x + i % 4;
				cy = y + i / 4;
				if (cx < WELL_X0 || cx >= WELL_X0 + WELL_COLS || cy >= WELL_Y0 + WELL_ROWS)
					return 1'b0;
				if (ref_board[cy * 64 + cx] != '0 && !is_own(cx, cy))
					return 1'b0;
			end
		end
		return 1'b1;
	endfunction

	task automatic paint(input int value);
		logic [15:0] m;
		m = shape_mask(m_kind, m_rot);
		for (int i = 0; i < 16; i++)
			if (m[i])
				ref_board[(m_y + i / 4) * 64 + m_x + i % 4] = color_t'(value);
	endtask

	function automatic int piece_col(input bit rightmost);
		logic [15:0] m;
		int          c;
		m = shape_mask(m_kind, m_rot);
		c = rightmost ? 0 : 99;
		for (int i = 0; i < 16; i++)
		begin
			if (m[i] && rightmost && (m_x + i % 4 > c))
				c = m_x + i % 4;
			else if (m[i] && !rightmost && (m_x + i % 4 < c))
				c = m_x + i % 4;
		end
		return c;
	endfunction

	task automatic model_frame(input bit l, input bit r, input bit ro);
		bit due;
		bit dn;
		bit lf;
		bit rt;
		bit ro_ok;
		m_next = (m_next == 7) ? 1 : m_next + 1;	// Advances on every frame
		due = (m_grav == GRAVITY - 1);
		m_grav = due ? 0 : m_grav + 1;
		dn = fits(m_rot, m_x, m_y + 1);
		lf = fits(m_rot, m_x - 1, m_y);
		rt = fits(m_rot, m_x + 1, m_y);
		ro_ok = fits(m_rot + 1, m_x, m_y);
		if (!(due && !dn))
			paint(0);	// Locked cells stay put
		if (due && dn)
			m_y = m_y + 1;
		else if (due)
		begin
			locks++;
			m_kind = m_next;
			m_rot = 0;
			m_x = WELL_X0 + SPAWN_X;
			m_y = WELL_Y0 + SPAWN_Y;
		end
		else if (ro && ro_ok)
		begin
			// Only a turn that moves cells shows on the board
			if (shape_mask(m_kind, m_rot) != shape_mask(m_kind, m_rot + 1))
				rotations++;
			m_rot = (m_rot + 1) % 4;
		end
		else if (l && lf)
			m_x = m_x - 1;
		else if (r && rt)
			m_x = m_x + 1;
		paint(m_kind);
	endtask

	////////////////////////////////////////////////////////////
	// Checks and frames

	task automatic check_value(input string name, input string what, input int expected,
		input int actual);
		checks++;
		assert (expected == actual)
		else
		begin
			$display("** Error %s: %s expected %0d actual %0d", name, what, expected, actual);
			test_errors++;
		end
	endtask

	task automatic check_goal(input string name, input bit ok, input string what);
		checks++;
		assert (ok)
		else
		begin
			$display("%s: %s", name, what);
			test_errors++;
		end
	endtask

	task automatic compare_board(input string name);
		for (int y = WELL_Y0; y < WELL_Y0 + WELL_ROWS; y++)
			for (int x = WELL_X0; x < WELL_X0 + WELL_COLS; x++)
			begin
				checks++;
				assert (board[y * 64 + x] === ref_board[y * 64 + x])
				else
				begin
					$display("** Error %s: cell row %0d col %0d expected %0d actual %0d",
						name, y, x, ref_board[y * 64 + x], board[y * 64 + x]);
					test_errors++;
				end
			end
	endtask

	// One frame, with an optional stray pulse while busy
	task automatic run_frame(input string name, input bit l, input bit r, input bit ro,
		input bit extra);
		int n;
		@(posedge clk);
		frame <= 1'b1;
		btn_left <= l;
		btn_right <= r;
		btn_rot <= ro;
		@(posedge clk);
		frame <= 1'b0;
		n = 0;
		@(negedge clk);
		while (busy && n < 64)
		begin
			n++;
			@(posedge clk);
			frame <= extra && (n == 10);
			@(negedge clk);
		end
		check_value(name, "busy cycles", 34, n);
		model_frame(l, r, ro);
		compare_board(name);	// Last write landed as busy fell
		repeat (FRAME_GAP) @(posedge clk);
	endtask

	task automatic run_test(input string name, input int frames, input logic [2:0] hold,
		input bit random_buttons);
		logic [2:0] btn;	// Left, right, rotate
		bit         extra;
		test_errors = 0;
		for (int f = 0; f < frames; f++)
		begin
			rng = lcg_next(rng);
			btn = random_buttons ? {rng[29], rng[28], rng[31] & rng[30]} : hold;
			extra = (rng[20:18] == 3'd0);	// About one frame in eight
			run_frame(name, btn[2], btn[1], btn[0], extra);
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		errors += test_errors;
		if (test_errors == 0)
			$display("test %s: ok", name);
		else
		begin
			tests_bad++;
			$display("test %s: %0d errors", name, test_errors);
		end
	endtask

	initial
	begin
		repeat (4) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);

		test_errors = 0;
		check_value("reset", "busy", 0, int'(busy));
		check_value("reset", "wr_en", 0, int'(wr_en));
		compare_board("reset");
		finish_test("reset");

		// I piece drops 18 rows, locks on frame 57, O piece spawns
		run_test("gravity", 58, 3'b000, 1'b0);
		check_value("gravity", "locks", 1, locks);
		check_value("gravity", "kind after lock", 2, m_kind);
		finish_test("gravity");

		run_test("left_wall", 14, 3'b100, 1'b0);
		check_value("left_wall", "leftmost column", WELL_X0, piece_col(1'b0));
		finish_test("left_wall");

		run_test("right_wall", 16, 3'b010, 1'b0);
		check_value("right_wall", "rightmost column", WELL_X0 + WELL_COLS - 1, piece_col(1'b1));
		finish_test("right_wall");

		// O piece lands on frame 114, then a J piece turns at spawn
		run_test("rotate", 32, 3'b001, 1'b0);
		check_goal("rotate", rotations > 0, "no piece changed shape on a rotation");
		finish_test("rotate");

		run_test("stacking", NUM_FRAMES - 120, 3'b000, 1'b1);
		check_goal("stacking", locks >= 3, "no piece locked during the random frames");
		finish_test("stacking");

		$display("summary: %0d tests, %0d with errors, %0d checks, %0d errors",
			tests_run, tests_bad, checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

/* flist.f */
logic/tetris_pkg.sv
logic/shape_rom.sv
logic/frame_sequencer.sv
logic/collision_checker.sv
logic/piece_state.sv
logic/board_writer.sv
logic/tetris_game.sv
testbench/tetris_game_chk.sv
testbench/tb_tetris_game.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_tetris_game -f flist.f
./obj_dir/Vtb_tetris_game > sim.log 2>&1 || true
cat sim.log
if grep -qx "all tests passed" sim.log
then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
